/* Bender.yml */
package:
  name: caliptra_ss_mbox

sources:
  - include_dirs:
      - include
    files:
      - hdl/mbox_cfg_pkg.sv
      - hdl/mbox_ecc_pkg.sv
      - hdl/mbox_addr_decode.sv
      - hdl/mbox_sram_issue.sv
      - hdl/mbox_ecc_check.sv
      - hdl/caliptra_ss_mbox_top.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_mbox_checker.sv
      - testbench/tb_caliptra_ss_mbox.sv

/* build.f */
+incdir+include
hdl/mbox_cfg_pkg.sv
hdl/mbox_ecc_pkg.sv
hdl/mbox_addr_decode.sv
hdl/mbox_sram_issue.sv
hdl/mbox_ecc_check.sv
hdl/caliptra_ss_mbox_top.sv
testbench/tb_clk_gen.sv
testbench/tb_mbox_checker.sv
testbench/tb_caliptra_ss_mbox.sv

/* hdl/caliptra_ss_mbox_top.sv */
module caliptra_ss_mbox_top (
    input  logic                                         cptra_ss_clk_i,
    input  logic                                         reset_i,

    // Request strobe
    input  logic                                         req_valid_i,
    input  logic                                         req_we_i,
    input  logic [mbox_cfg_pkg::MBOX_REQ_ADDR_W-1:0]     req_addr_i,
    input  logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]         req_wdata_i,
    input  logic [mbox_cfg_pkg::MBOX_REQ_ADDR_W-1:0]     strap_mbox_base_addr_i,

    // SRAM interface for mbox
    output logic                                         mbox_sram_cs_o,
    output logic                                         mbox_sram_we_o,
    output logic [mbox_cfg_pkg::MBOX_ADDR_W-1:0]         mbox_sram_addr_o,
    output logic [mbox_cfg_pkg::MBOX_DATA_AND_ECC_W-1:0] mbox_sram_wdata_o,
    input  logic [mbox_cfg_pkg::MBOX_DATA_AND_ECC_W-1:0] mbox_sram_rdata_i,

    // Response and errors
    output logic                                         rsp_valid_o,
    output logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]         rsp_rdata_o,
    output logic                                         rsp_err_o,
    output logic                                         error_fatal_o,
    output logic                                         error_non_fatal_o
);

    import mbox_cfg_pkg::*;

    logic                   dec_valid;
    logic                   dec_we;
    logic                   dec_oob;
    logic [MBOX_ADDR_W-1:0] dec_index;
    logic [MBOX_DATA_W-1:0] dec_wdata;

    logic                   iss_valid;
    logic                   iss_we;
    logic                   iss_oob;

    mbox_addr_decode i_addr_decode (
        .cptra_ss_clk_i,
        .reset_i,
        .req_valid_i,
        .req_we_i,
        .req_addr_i,
        .req_wdata_i,
        .strap_mbox_base_addr_i,
        .dec_valid_o (dec_valid),
        .dec_we_o    (dec_we),
        .dec_oob_o   (dec_oob),
        .dec_index_o (dec_index),
        .dec_wdata_o (dec_wdata)
    );

    mbox_sram_issue i_sram_issue (
        .cptra_ss_clk_i,
        .reset_i,
        .dec_valid_i (dec_valid),
        .dec_we_i    (dec_we),
        .dec_oob_i   (dec_oob),
        .dec_index_i (dec_index),
        .dec_wdata_i (dec_wdata),
        .mbox_sram_cs_o,
        .mbox_sram_we_o,
        .mbox_sram_addr_o,
        .mbox_sram_wdata_o,
        .iss_valid_o (iss_valid),
        .iss_we_o    (iss_we),
        .iss_oob_o   (iss_oob)
    );

    mbox_ecc_check i_ecc_check (
        .cptra_ss_clk_i,
        .reset_i,
        .iss_valid_i (iss_valid),
        .iss_we_i    (iss_we),
        .iss_oob_i   (iss_oob),
        .mbox_sram_rdata_i,
        .rsp_valid_o,
        .rsp_rdata_o,
        .rsp_err_o,
        .error_fatal_o,
        .error_non_fatal_o
    );

endmodule

/* hdl/mbox_addr_decode.sv */
`include "mbox_assert.svh"

module mbox_addr_decode (
    input  logic                                      cptra_ss_clk_i,
    input  logic                                      reset_i,
    input  logic                                      req_valid_i,
    input  logic                                      req_we_i,
    input  logic [mbox_cfg_pkg::MBOX_REQ_ADDR_W-1:0]  req_addr_i,
    input  logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]      req_wdata_i,
    input  logic [mbox_cfg_pkg::MBOX_REQ_ADDR_W-1:0]  strap_mbox_base_addr_i,
    output logic                                      dec_valid_o,
    output logic                                      dec_we_o,
    output logic                                      dec_oob_o,
    output logic [mbox_cfg_pkg::MBOX_ADDR_W-1:0]      dec_index_o,
    output logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]      dec_wdata_o
);

    import mbox_cfg_pkg::*;

    logic [MBOX_REQ_ADDR_W-1:0] offset;
    logic                       in_window;
    logic                       aligned;

    // Byte offset into the mailbox, wraps below the base
    assign offset    = req_addr_i - strap_mbox_base_addr_i;
    assign in_window = offset < MBOX_REQ_ADDR_W'(MBOX_SIZE_BYTES);
    assign aligned   = offset[MBOX_BYTE_OFF_W-1:0] == '0;

    always_ff @(posedge cptra_ss_clk_i) begin
        if (reset_i) begin
            dec_valid_o <= 1'b0;
            dec_we_o    <= 1'b0;
            dec_oob_o   <= 1'b0;
        end else begin
            dec_valid_o <= req_valid_i;
            dec_we_o    <= req_valid_i & req_we_i;
            dec_oob_o   <= req_valid_i & ~(in_window & aligned);
        end
    end

    // Payload
    always_ff @(posedge cptra_ss_clk_i) begin
        if (req_valid_i) begin
            dec_index_o <= offset[MBOX_BYTE_OFF_W +: MBOX_ADDR_W];
            dec_wdata_o <= req_wdata_i;
        end
    end

    // Index of an accepted request maps back onto the address it came from
    `MBOX_ASSERT(a_dec_index_in_window, cptra_ss_clk_i,
        dec_valid_o && !dec_oob_o |->
            MBOX_REQ_ADDR_W'({dec_index_o, {MBOX_BYTE_OFF_W{1'b0}}})
                + $past(strap_mbox_base_addr_i) == $past(req_addr_i))

endmodule

/* hdl/mbox_cfg_pkg.sv */
package mbox_cfg_pkg;

    // --------------------------------------------------
    // Word geometry
    // --------------------------------------------------

    // Payload bits per mailbox word
    localparam int unsigned MBOX_DATA_W = 32;

    // Hamming check bits plus overall parity
    localparam int unsigned MBOX_ECC_W = 7;

    // As stored in the SRAM macro
    localparam int unsigned MBOX_DATA_AND_ECC_W = MBOX_DATA_W + MBOX_ECC_W;

    // --------------------------------------------------
    // Address window
    // --------------------------------------------------

    localparam int unsigned MBOX_SIZE_BYTES = 1024;

    // Word index into the SRAM, 256 entries
    localparam int unsigned MBOX_ADDR_W = 8;

    // Byte address as seen on the request side
    localparam int unsigned MBOX_REQ_ADDR_W = 32;

    // Low address bits below a word boundary
    localparam int unsigned MBOX_BYTE_OFF_W = 2;

endpackage

/* hdl/mbox_ecc_check.sv */
`include "mbox_assert.svh"

module mbox_ecc_check (
    input  logic                                         cptra_ss_clk_i,
    input  logic                                         reset_i,
    input  logic                                         iss_valid_i,
    input  logic                                         iss_we_i,
    input  logic                                         iss_oob_i,
    input  logic [mbox_cfg_pkg::MBOX_DATA_AND_ECC_W-1:0] mbox_sram_rdata_i,
    output logic                                         rsp_valid_o,
    output logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]         rsp_rdata_o,
    output logic                                         rsp_err_o,
    output logic                                         error_fatal_o,
    output logic                                         error_non_fatal_o
);

    import mbox_cfg_pkg::*;
    import mbox_ecc_pkg::*;

    mbox_sram_word_u        rd_word;
    logic [MBOX_SYN_W:0]    syn_res;
    logic [MBOX_SYN_W-1:0]  syn_bits;
    logic                   syn_odd;
    logic [MBOX_DATA_W-1:0] flip_mask;
    logic [MBOX_DATA_W-1:0] fixed_data;
    logic                   rd_chk;
    logic                   single_err;
    logic                   double_err;

    // --------------------------------------------------
    // Syndrome and correction
    // --------------------------------------------------
    assign rd_word.raw = mbox_sram_rdata_i;
    assign syn_res     = mbox_ecc_syndrome(rd_word);
    assign syn_odd     = syn_res[MBOX_SYN_W];
    assign syn_bits    = syn_res[MBOX_SYN_W-1:0];

    // Flip only a data bit; a hit on a check bit leaves data alone
    always_comb begin
        flip_mask = '0;
        for (int unsigned i = 0; i < MBOX_DATA_W; i++) begin
            flip_mask[i] = syn_odd && (syn_bits == mbox_ecc_data_pos(i));
        end
    end

    assign fixed_data = rd_word.f.data ^ flip_mask;

    // Only a read that actually touched the SRAM is checked
    assign rd_chk     = iss_valid_i & ~iss_we_i & ~iss_oob_i;
    assign single_err = rd_chk & syn_odd;
    assign double_err = rd_chk & ~syn_odd & (syn_bits != '0);

    // --------------------------------------------------
    // Response
    // --------------------------------------------------
    always_ff @(posedge cptra_ss_clk_i) begin
        if (reset_i) begin
            rsp_valid_o       <= 1'b0;
            rsp_err_o         <= 1'b0;
            error_non_fatal_o <= 1'b0;
            error_fatal_o     <= 1'b0;
        end else begin
            rsp_valid_o       <= iss_valid_i;
            rsp_err_o         <= (iss_valid_i & iss_oob_i) | double_err;
            error_non_fatal_o <= single_err;
            // Sticky until reset
            error_fatal_o     <= error_fatal_o | double_err;
        end
    end

    // Writes, out-of-window and uncorrectable reads return zero
    always_ff @(posedge cptra_ss_clk_i) begin
        if (iss_valid_i) begin
            rsp_rdata_o <= (rd_chk && !double_err) ? fixed_data : '0;
        end
    end

    `MBOX_ASSERT(a_non_fatal_with_rsp, cptra_ss_clk_i,
        error_non_fatal_o |-> rsp_valid_o && !rsp_err_o)

endmodule

/* hdl/mbox_ecc_pkg.sv */
package mbox_ecc_pkg;

    import mbox_cfg_pkg::*;

    // Hamming part of the check field, overall parity sits above it
    localparam int unsigned MBOX_SYN_W = MBOX_ECC_W - 1;

    // Length of the Hamming codeword without the overall parity bit
    localparam int unsigned MBOX_HAM_N = MBOX_DATA_W + MBOX_SYN_W;

    // --------------------------------------------------
    // Stored word, seen whole or split into fields
    // --------------------------------------------------
    typedef union packed {
        logic [MBOX_DATA_AND_ECC_W-1:0] raw;
        struct packed {
            logic [MBOX_ECC_W-1:0]  ecc;
            logic [MBOX_DATA_W-1:0] data;
        } f;
    } mbox_sram_word_u;

    // Codeword position of a data bit, skipping the power-of-two slots
    function automatic logic [MBOX_SYN_W-1:0] mbox_ecc_data_pos(input int unsigned idx);
        int unsigned cnt;
        logic [MBOX_SYN_W-1:0] pos;
        cnt = 0;
        pos = '0;
        for (int unsigned p = 1; p <= MBOX_HAM_N; p++) begin
            if ((p & (p - 1)) != 0) begin
                if (cnt == idx) begin
                    pos = MBOX_SYN_W'(p);
                end
                cnt++;
            end
        end
        return pos;
    endfunction

    // Check bits of a data word, parity over the whole word in the top bit
    function automatic logic [MBOX_ECC_W-1:0] mbox_ecc_encode(
        input logic [MBOX_DATA_W-1:0] data
    );
        logic [MBOX_SYN_W-1:0] chk;
        logic [MBOX_SYN_W-1:0] pos;
        chk = '0;
        for (int unsigned i = 0; i < MBOX_DATA_W; i++) begin
            pos = mbox_ecc_data_pos(i);
            for (int unsigned j = 0; j < MBOX_SYN_W; j++) begin
                if (pos[j]) begin
                    chk[j] = chk[j] ^ data[i];
                end
            end
        end
        return {^{chk, data}, chk};
    endfunction

    // Result is {odd overall parity, syndrome}
    // A nonzero syndrome names the codeword position that flipped
    function automatic logic [MBOX_SYN_W:0] mbox_ecc_syndrome(input mbox_sram_word_u word);
        logic [MBOX_ECC_W-1:0] chk;
        chk = mbox_ecc_encode(word.f.data);
        return {^word.raw, chk[MBOX_SYN_W-1:0] ^ word.f.ecc[MBOX_SYN_W-1:0]};
    endfunction

endpackage

/* hdl/mbox_sram_issue.sv */
`include "mbox_assert.svh"

module mbox_sram_issue (
    input  logic                                         cptra_ss_clk_i,
    input  logic                                         reset_i,
    input  logic                                         dec_valid_i,
    input  logic                                         dec_we_i,
    input  logic                                         dec_oob_i,
    input  logic [mbox_cfg_pkg::MBOX_ADDR_W-1:0]         dec_index_i,
    input  logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]         dec_wdata_i,
    output logic                                         mbox_sram_cs_o,
    output logic                                         mbox_sram_we_o,
    output logic [mbox_cfg_pkg::MBOX_ADDR_W-1:0]         mbox_sram_addr_o,
    output logic [mbox_cfg_pkg::MBOX_DATA_AND_ECC_W-1:0] mbox_sram_wdata_o,
    output logic                                         iss_valid_o,
    output logic                                         iss_we_o,
    output logic                                         iss_oob_o
);

    import mbox_cfg_pkg::*;
    import mbox_ecc_pkg::*;

    mbox_sram_word_u wr_word;
    logic            access;

    // Tag of the request sitting on the SRAM port
    logic            pend_valid;
    logic            pend_we;
    logic            pend_oob;

    assign access = dec_valid_i & ~dec_oob_i;

    always_comb begin
        wr_word.f.data = dec_wdata_i;
        wr_word.f.ecc  = mbox_ecc_encode(dec_wdata_i);
    end

    always_ff @(posedge cptra_ss_clk_i) begin
        if (reset_i) begin
            mbox_sram_cs_o <= 1'b0;
            mbox_sram_we_o <= 1'b0;
            pend_valid     <= 1'b0;
            pend_we        <= 1'b0;
            pend_oob       <= 1'b0;
            iss_valid_o    <= 1'b0;
            iss_we_o       <= 1'b0;
            iss_oob_o      <= 1'b0;
        end else begin
            mbox_sram_cs_o <= access;
            mbox_sram_we_o <= access & dec_we_i;
            pend_valid     <= dec_valid_i;
            pend_we        <= dec_we_i;
            pend_oob       <= dec_oob_i;
            // Read data comes back one cycle after the port, tag follows it
            iss_valid_o    <= pend_valid;
            iss_we_o       <= pend_we;
            iss_oob_o      <= pend_oob;
        end
    end

    always_ff @(posedge cptra_ss_clk_i) begin
        if (access) begin
            mbox_sram_addr_o  <= dec_index_i;
            mbox_sram_wdata_o <= wr_word.raw;
        end
    end

    // A write on the port needs chip select and its tag reaches stage 3 a cycle later
    `MBOX_ASSERT(a_we_needs_cs, cptra_ss_clk_i,
        mbox_sram_we_o |-> mbox_sram_cs_o ##1 (iss_valid_o && iss_we_o && !iss_oob_o))

endmodule

/* include/mbox_assert.svh */
`ifndef MBOX_ASSERT_SVH
`define MBOX_ASSERT_SVH

// Concurrent check sampled on the rising clock edge
// Quiet while reset_i is high
`define MBOX_ASSERT(name_, clk_, prop_) \
    name_: assert property ( \
        @(posedge clk_) disable iff (reset_i) (prop_) \
    ) else begin \
        $error("%m failed"); \
    end

`endif

/* testbench/tb_caliptra_ss_mbox.sv */
module tb_caliptra_ss_mbox;

    import mbox_cfg_pkg::*;

    localparam int N_CLEAN  = 64;
    localparam int N_SINGLE = 32;
    localparam int N_OOB    = 40;
    localparam int N_MIX    = 200;
    localparam int N_DOUBLE = 16;
    localparam int N_REQ    = 256 + N_CLEAN + 2 * N_SINGLE + N_OOB + N_MIX + 2 * N_DOUBLE;
    localparam int TIMEOUT_CYC = N_REQ * 10 + 100;

    logic                           cptra_ss_clk_i;
    logic                           reset_i;
    logic                           req_valid_i;
    logic                           req_we_i;
    logic [MBOX_REQ_ADDR_W-1:0]     req_addr_i;
    logic [MBOX_DATA_W-1:0]         req_wdata_i;
    logic [MBOX_REQ_ADDR_W-1:0]     strap_mbox_base_addr_i;
    logic                           mbox_sram_cs_o;
    logic                           mbox_sram_we_o;
    logic [MBOX_ADDR_W-1:0]         mbox_sram_addr_o;
    logic [MBOX_DATA_AND_ECC_W-1:0] mbox_sram_wdata_o;
    logic [MBOX_DATA_AND_ECC_W-1:0] mbox_sram_rdata_i;
    logic                           rsp_valid_o;
    logic [MBOX_DATA_W-1:0]         rsp_rdata_o;
    logic                           rsp_err_o;
    logic                           error_fatal_o;
    logic                           error_non_fatal_o;

    int                             req_flips;
    int                             pending;
    int                             err_count;
    int                             checked;
    int                             tests;

    // SRAM model with bit flips injected on write
    logic [MBOX_DATA_AND_ECC_W-1:0] sram [256];
    int                             flip_q [$];
    logic [MBOX_ADDR_W-1:0]         wr_idx [$];
    logic [MBOX_ADDR_W-1:0]         rd_idx [$];

    tb_clk_gen i_clk_gen (
        .clk_o (cptra_ss_clk_i)
    );

    caliptra_ss_mbox_top i_dut (
        .cptra_ss_clk_i,
        .reset_i,
        .req_valid_i,
        .req_we_i,
        .req_addr_i,
        .req_wdata_i,
        .strap_mbox_base_addr_i,
        .mbox_sram_cs_o,
        .mbox_sram_we_o,
        .mbox_sram_addr_o,
        .mbox_sram_wdata_o,
        .mbox_sram_rdata_i,
        .rsp_valid_o,
        .rsp_rdata_o,
        .rsp_err_o,
        .error_fatal_o,
        .error_non_fatal_o
    );

    tb_mbox_checker i_chk (
        .clk_i        (cptra_ss_clk_i),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_we_i     (req_we_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .strap_i      (strap_mbox_base_addr_i),
        .req_flips_i  (req_flips),
        .sram_cs_i    (mbox_sram_cs_o),
        .sram_we_i    (mbox_sram_we_o),
        .sram_addr_i  (mbox_sram_addr_o),
        .sram_wdata_i (mbox_sram_wdata_o[MBOX_DATA_W-1:0]),
        .rsp_valid_i  (rsp_valid_o),
        .rsp_rdata_i  (rsp_rdata_o),
        .rsp_err_i    (rsp_err_o),
        .fatal_i      (error_fatal_o),
        .non_fatal_i  (error_non_fatal_o),
        .pending_o    (pending),
        .err_count_o  (err_count),
        .checked_o    (checked)
    );

    function automatic logic [MBOX_DATA_AND_ECC_W-1:0] flip_mask(input int n);
        logic [MBOX_DATA_AND_ECC_W-1:0] m;
        int                             b0;
        int                             b1;
        m  = '0;
        b0 = $urandom % MBOX_DATA_AND_ECC_W;
        b1 = (b0 + 1 + $urandom % (MBOX_DATA_AND_ECC_W - 1)) % MBOX_DATA_AND_ECC_W;
        if (n >= 1) begin
            m[b0] = 1'b1;
        end
        if (n >= 2) begin
            m[b1] = 1'b1;
        end
        return m;
    endfunction

    // Read data is valid the cycle after chip select
    always @(posedge cptra_ss_clk_i) begin
        if (mbox_sram_cs_o && mbox_sram_we_o) begin
            if (flip_q.size() == 0) begin
                $display("SRAM write at %0t with no pending stimulus write", $time);
                i_chk.note_failure();
                sram[mbox_sram_addr_o] <= mbox_sram_wdata_o;
            end else begin
                sram[mbox_sram_addr_o] <= mbox_sram_wdata_o ^ flip_mask(flip_q.pop_front());
            end
        end else if (mbox_sram_cs_o) begin
            mbox_sram_rdata_i <= sram[mbox_sram_addr_o];
        end
    end

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    function automatic logic [31:0] win_addr(input logic [MBOX_ADDR_W-1:0] idx);
        return strap_mbox_base_addr_i + {idx, 2'b00};
    endfunction

    function automatic logic [31:0] oob_addr();
        case ($urandom % 3)
            0:       return win_addr($urandom) + 1 + $urandom % 3;
            1:       return strap_mbox_base_addr_i + MBOX_SIZE_BYTES + ($urandom % 4096) * 4;
            default: return strap_mbox_base_addr_i - 4 - ($urandom % 4096) * 4;
        endcase
    endfunction

    task automatic send(input logic we, input logic [31:0] addr, input int flips,
                        input bit in_win);
        if (we && in_win) begin
            flip_q.push_back(flips);
        end
        req_valid_i <= 1'b1;
        req_we_i    <= we;
        req_addr_i  <= addr;
        req_wdata_i <= $urandom;
        req_flips   <= flips;
        @(posedge cptra_ss_clk_i);
    endtask

    task automatic drain(input string name);
        req_valid_i <= 1'b0;
        @(posedge cptra_ss_clk_i);
        while (pending != 0) begin
            @(posedge cptra_ss_clk_i);
        end
        i_chk.report_test(name);
        tests++;
    endtask

    initial begin
        int r;
        logic [MBOX_ADDR_W-1:0] idx;
        r = $urandom(32'h956c966c);
        tests = 0;
        reset_i                <= 1'b1;
        req_valid_i            <= 1'b0;
        req_we_i               <= 1'b0;
        req_addr_i             <= '0;
        req_wdata_i            <= '0;
        req_flips              <= 0;
        strap_mbox_base_addr_i <= 32'h2000_0000 | ($urandom & 32'h00ff_fffc);
        mbox_sram_rdata_i      <= '0;
        repeat (5) @(posedge cptra_ss_clk_i);
        reset_i <= 1'b0;
        @(posedge cptra_ss_clk_i);
        i_chk.check_idle();
        i_chk.report_test("reset");
        tests++;

        // Fill every word clean, then read some back
        for (int i = 0; i < 256; i++) begin
            send(1'b1, win_addr(i), 0, 1'b1);
        end
        for (int i = 0; i < N_CLEAN; i++) begin
            send(1'b0, win_addr($urandom), 0, 1'b1);
        end
        drain("clean");

        for (int i = 0; i < N_SINGLE; i++) begin
            idx = $urandom;
            wr_idx.push_back(idx);
            send(1'b1, win_addr(idx), 1, 1'b1);
        end
        while (wr_idx.size() > 0) begin
            send(1'b0, win_addr(wr_idx.pop_front()), 0, 1'b1);
        end
        drain("single");

        for (int i = 0; i < N_OOB; i++) begin
            send($urandom % 2, oob_addr(), 0, 1'b0);
        end
        drain("oob");

        // Back-to-back mix, flips limited to one bit
        for (int i = 0; i < N_MIX; i++) begin
            r = $urandom % 4;
            if (r == 0) begin
                send($urandom % 2, oob_addr(), 0, 1'b0);
            end else begin
                send(r == 1, win_addr($urandom), $urandom % 2, 1'b1);
            end
        end
        drain("mixed");

        for (int i = 0; i < N_DOUBLE; i++) begin
            idx = $urandom;
            rd_idx.push_back(idx);
            send(1'b1, win_addr(idx), 2, 1'b1);
        end
        while (rd_idx.size() > 0) begin
            send(1'b0, win_addr(rd_idx.pop_front()), 0, 1'b1);
        end
        drain("double");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checked, err_count);
        if (err_count == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #((TIMEOUT_CYC + 5) * 100);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* testbench/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk_o
);

    // Period of 100 time units
    initial begin
        clk_o = 1'b0;
    end

    always begin
        #50;
        clk_o = ~clk_o;
    end

endmodule

/* testbench/tb_mbox_checker.sv */
module tb_mbox_checker (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     req_valid_i,
    input  logic                                     req_we_i,
    input  logic [mbox_cfg_pkg::MBOX_REQ_ADDR_W-1:0] req_addr_i,
    input  logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]     req_wdata_i,
    input  logic [mbox_cfg_pkg::MBOX_REQ_ADDR_W-1:0] strap_i,
    input  int                                       req_flips_i,
    input  logic                                     sram_cs_i,
    input  logic                                     sram_we_i,
    input  logic [mbox_cfg_pkg::MBOX_ADDR_W-1:0]     sram_addr_i,
    input  logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]     sram_wdata_i,
    input  logic                                     rsp_valid_i,
    input  logic [mbox_cfg_pkg::MBOX_DATA_W-1:0]     rsp_rdata_i,
    input  logic                                     rsp_err_i,
    input  logic                                     fatal_i,
    input  logic                                     non_fatal_i,
    output int                                       pending_o,
    output int                                       err_count_o,
    output int                                       checked_o
);

    import mbox_cfg_pkg::*;

    // Model memory holds data as written, flips kept apart
    logic [MBOX_DATA_W-1:0] mem_data [256];
    int                     mem_flips [256];

    int                     cycle;
    int                     due_q [$];
    logic [MBOX_DATA_W-1:0] data_q [$];
    bit                     err_q [$];
    bit                     nf_q [$];
    bit                     dbl_q [$];
    int                     acc_due_q [$];
    logic [MBOX_ADDR_W-1:0] acc_idx_q [$];
    bit                     acc_we_q [$];
    logic [MBOX_DATA_W-1:0] acc_wd_q [$];
    bit                     exp_fatal;
    int                     test_checks;
    int                     test_errs;

    initial begin
        pending_o   = 0;
        err_count_o = 0;
        checked_o   = 0;
        exp_fatal   = 1'b0;
        test_checks = 0;
        test_errs   = 0;
        for (int i = 0; i < 256; i++) begin
            mem_data[i]  = '0;
            mem_flips[i] = 0;
        end
    end

    task automatic note_failure();
        test_errs++;
        err_count_o++;
    endtask

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        test_checks++;
        checked_o++;
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
            note_failure();
        end
    endtask

    task automatic check_idle();
        compare("rsp_valid_o", 0, rsp_valid_i);
        compare("mbox_sram_cs_o", 0, sram_cs_i);
        compare("mbox_sram_we_o", 0, sram_we_i);
        compare("error_fatal_o", 0, fatal_i);
        compare("error_non_fatal_o", 0, non_fatal_i);
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished: %0d checks, %0d errors", name, test_checks, test_errs);
        test_checks = 0;
        test_errs   = 0;
    endtask

    always @(posedge clk_i) begin : watch
        logic [MBOX_REQ_ADDR_W-1:0] off;
        logic [MBOX_ADDR_W-1:0]     idx;
        bit                         oob;
        logic [MBOX_DATA_W-1:0]     exp_rd;
        bit                         exp_err;
        bit                         exp_nf;
        bit                         exp_dbl;
        if (!reset_i) begin
            cycle++;

            // --------------------------------------------------
            // Responses
            // --------------------------------------------------
            if (due_q.size() > 0 && due_q[0] == cycle) begin
                if (!rsp_valid_i) begin
                    $display("Response missing at %0t, rsp_valid_o stayed low", $time);
                    note_failure();
                end else begin
                    if (dbl_q[0]) begin
                        exp_fatal = 1'b1;
                    end
                    compare("rsp_err_o", err_q[0], rsp_err_i);
                    compare("rsp_rdata_o", data_q[0], rsp_rdata_i);
                    compare("error_non_fatal_o", nf_q[0], non_fatal_i);
                end
                void'(due_q.pop_front());
                void'(data_q.pop_front());
                void'(err_q.pop_front());
                void'(nf_q.pop_front());
                void'(dbl_q.pop_front());
            end else begin
                if (rsp_valid_i) begin
                    $display("Response at %0t with no request due", $time);
                    note_failure();
                end
                if (non_fatal_i) begin
                    $display("Non-fatal error pulse at %0t outside a response", $time);
                    note_failure();
                end
            end
            if (fatal_i !== exp_fatal) begin
                $display("** Error at %0t: error_fatal_o expected %b, got %b",
                         $time, exp_fatal, fatal_i);
                note_failure();
            end

            // SRAM port, only accepted requests may touch it
            if (acc_due_q.size() > 0 && acc_due_q[0] == cycle) begin
                if (!sram_cs_i) begin
                    $display("SRAM chip select missing at %0t", $time);
                    note_failure();
                end else begin
                    compare("mbox_sram_addr_o", acc_idx_q[0], sram_addr_i);
                    compare("mbox_sram_we_o", acc_we_q[0], sram_we_i);
                    if (acc_we_q[0]) begin
                        compare("mbox_sram_wdata_o", acc_wd_q[0], sram_wdata_i);
                    end
                end
                void'(acc_due_q.pop_front());
                void'(acc_idx_q.pop_front());
                void'(acc_we_q.pop_front());
                void'(acc_wd_q.pop_front());
            end else if (sram_cs_i) begin
                $display("SRAM chip select raised at %0t for no accepted request", $time);
                note_failure();
            end

            // --------------------------------------------------
            // New request
            // --------------------------------------------------
            if (req_valid_i) begin
                off     = req_addr_i - strap_i;
                oob     = (off >= MBOX_SIZE_BYTES) || (off[1:0] != 2'b00);
                idx     = off[9:2];
                exp_rd  = '0;
                exp_err = oob;
                exp_nf  = 1'b0;
                exp_dbl = 1'b0;
                if (!oob) begin
                    acc_due_q.push_back(cycle + 2);
                    acc_idx_q.push_back(idx);
                    acc_we_q.push_back(req_we_i);
                    acc_wd_q.push_back(req_wdata_i);
                    if (req_we_i) begin
                        mem_data[idx]  = req_wdata_i;
                        mem_flips[idx] = req_flips_i;
                    end else if (mem_flips[idx] >= 2) begin
                        exp_err = 1'b1;
                        exp_dbl = 1'b1;
                    end else begin
                        exp_rd = mem_data[idx];
                        exp_nf = mem_flips[idx] == 1;
                    end
                end
                due_q.push_back(cycle + 4);
                data_q.push_back(exp_rd);
                err_q.push_back(exp_err);
                nf_q.push_back(exp_nf);
                dbl_q.push_back(exp_dbl);
            end
            pending_o = due_q.size() + acc_due_q.size();
        end
    end

endmodule
